// File: design/leaf_pkg.sv
package leaf_pkg;

    // Tree bus and user word widths.
    localparam int PACKET_BITS  = 49;
    localparam int PAYLOAD_BITS = 32;

    // Packet header fields.
    localparam int LEAF_BITS = 5;
    localparam int PORT_BITS = 4;
    localparam int ADDR_BITS = 7;

    // Unused tail of a config packet.
    localparam int RSVD_BITS = PACKET_BITS - 1 - 2 * LEAF_BITS - 2 * PORT_BITS;

    localparam int NUM_IN_PORTS = 6;

    localparam logic [LEAF_BITS-1:0] LEAF_ID  = 5'd5;  // Address of this leaf.
    localparam logic [PORT_BITS-1:0] CFG_PORT = 4'd0;  // Route config packets.

    // Input port buffer sizing.
    localparam int FIFO_DEPTH    = 8;
    localparam int FIFO_PTR_BITS = 3;

    // One tree word, read either as data or as a route update.
    typedef union packed {
        struct packed {
            logic                    valid;
            logic [LEAF_BITS-1:0]    leaf;
            logic [PORT_BITS-1:0]    port;
            logic [ADDR_BITS-1:0]    addr;
            logic [PAYLOAD_BITS-1:0] payload;
        } data;
        struct packed {
            logic                    valid;
            logic [LEAF_BITS-1:0]    leaf;
            logic [PORT_BITS-1:0]    port;
            logic [LEAF_BITS-1:0]    dest_leaf;  // New output route.
            logic [PORT_BITS-1:0]    dest_port;
            logic [RSVD_BITS-1:0]    reserved;
        } cfg;
    } leaf_packet_u;

endpackage

// File: design/leaf_packet_decoder.sv
`timescale 1ns/1ns

module leaf_packet_decoder (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  leaf_pkg::leaf_packet_u               din,
    output logic [leaf_pkg::NUM_IN_PORTS-1:0]    wr_en,
    output logic [leaf_pkg::PAYLOAD_BITS-1:0]    wr_data,
    output logic [leaf_pkg::LEAF_BITS-1:0]       route_leaf,
    output logic [leaf_pkg::PORT_BITS-1:0]       route_port
);

    logic for_me;   // Valid and addressed to this leaf.
    logic cfg_hit;

    assign for_me  = din.data.valid && (din.data.leaf == leaf_pkg::LEAF_ID);
    assign cfg_hit = for_me && (din.data.port == leaf_pkg::CFG_PORT);

    // Payload goes to every buffer; only the addressed one is written.
    assign wr_data = din.data.payload;

    // Port n lands in buffer n-1. Ports above 6 match nothing.
    always_comb begin
        wr_en = '0;
        for (int i = 0; i < leaf_pkg::NUM_IN_PORTS; i++) begin
            if (for_me && (din.data.port == leaf_pkg::PORT_BITS'(i + 1))) begin
                wr_en[i] = 1'b1;
            end
        end
    end

    // Route register for the outgoing packets.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            route_leaf <= '0;
            route_port <= '0;
        end else if (cfg_hit) begin
            route_leaf <= din.cfg.dest_leaf;
            route_port <= din.cfg.dest_port;
        end
    end

    // A packet has one port field, so at most one buffer is written.
    a_wr_onehot: assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot0(wr_en)
    ) else $error("decoder wrote more than one port buffer");

endmodule

// File: design/leaf_in_port.sv
`timescale 1ns/1ns

module leaf_in_port (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              wr_en,
    input  logic [leaf_pkg::PAYLOAD_BITS-1:0] wr_data,
    output logic                              vld,
    output logic [leaf_pkg::PAYLOAD_BITS-1:0] dout,
    input  logic                              ack
);

    localparam int CNT_BITS = leaf_pkg::FIFO_PTR_BITS + 1;

    logic [leaf_pkg::PAYLOAD_BITS-1:0]  mem [leaf_pkg::FIFO_DEPTH];
    logic [leaf_pkg::FIFO_PTR_BITS-1:0] wr_ptr;
    logic [leaf_pkg::FIFO_PTR_BITS-1:0] rd_ptr;
    logic [CNT_BITS-1:0]                count;
    logic                               full;
    logic                               push;
    logic                               pop;

    assign full = (count == CNT_BITS'(leaf_pkg::FIFO_DEPTH));
    assign push = wr_en && !full;  // Writes to a full buffer are lost.
    assign pop  = ack && vld;

    // Head of the buffer is always on the output.
    assign vld  = (count != '0);
    assign dout = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // Pointers wrap on their own since the depth is a power of two.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // The consumer may only take a word that is on offer.
    a_ack_needs_vld: assert property (
        @(posedge clk) disable iff (!rst_n)
        ack |-> vld
    ) else $error("ack while buffer empty");

    // An offered word stays until taken.
    a_word_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        (vld && !ack) |=> (vld && $stable(dout))
    ) else $error("buffer head changed before ack");

endmodule

// File: design/leaf_reduce_kernel.sv
`timescale 1ns/1ns

module leaf_reduce_kernel (
    input  logic                                                          clk,
    input  logic                                                          rst_n,
    input  logic [leaf_pkg::NUM_IN_PORTS-1:0]                             vld,
    input  logic [leaf_pkg::NUM_IN_PORTS-1:0][leaf_pkg::PAYLOAD_BITS-1:0] din,
    output logic [leaf_pkg::NUM_IN_PORTS-1:0]                             ack,
    output logic                                                          sum_vld,
    output logic [leaf_pkg::PAYLOAD_BITS-1:0]                             sum_data,
    output logic [leaf_pkg::ADDR_BITS-1:0]                                sum_seq,
    input  logic                                                          sum_ack
);

    logic                              fire;
    logic [leaf_pkg::PAYLOAD_BITS-1:0] sum_next;
    logic [leaf_pkg::ADDR_BITS-1:0]    seq_cnt;   // Number of the next set.

    // Take a full set only when the result register frees up.
    assign fire = (&vld) && (!sum_vld || sum_ack);
    assign ack  = {leaf_pkg::NUM_IN_PORTS{fire}};

    // Carries out of bit 31 are dropped.
    always_comb begin
        sum_next = '0;
        for (int i = 0; i < leaf_pkg::NUM_IN_PORTS; i++) begin
            sum_next = sum_next + din[i];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sum_vld <= 1'b0;
            seq_cnt <= '0;
        end else if (fire) begin
            sum_vld <= 1'b1;
            seq_cnt <= seq_cnt + 1'b1;  // Wraps at 128.
        end else if (sum_ack) begin
            sum_vld <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            sum_data <= sum_next;
            sum_seq  <= seq_cnt;
        end
    end

    // All six streams advance together.
    a_ack_all_or_none: assert property (
        @(posedge clk) disable iff (!rst_n)
        (ack == '0) || (ack == '1)
    ) else $error("partial ack across ports");

endmodule

// File: design/leaf_packet_encoder.sv
`timescale 1ns/1ns

module leaf_packet_encoder (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              sum_vld,
    input  logic [leaf_pkg::PAYLOAD_BITS-1:0] sum_data,
    input  logic [leaf_pkg::ADDR_BITS-1:0]    sum_seq,
    output logic                              sum_ack,
    input  logic [leaf_pkg::LEAF_BITS-1:0]    route_leaf,
    input  logic [leaf_pkg::PORT_BITS-1:0]    route_port,
    input  logic                              resend,
    output leaf_pkg::leaf_packet_u            dout
);

    leaf_pkg::leaf_packet_u pkt_q;
    logic                   pkt_vld;  // A packet is waiting to go out.
    logic                   shown;

    // Held packet leaves on any cycle without resend.
    assign shown = pkt_vld && !resend;

    // Entry is free or draining whenever resend is low.
    assign sum_ack = sum_vld && !resend;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pkt_vld <= 1'b0;
        end else if (sum_ack) begin
            pkt_vld <= 1'b1;
        end else if (shown) begin
            pkt_vld <= 1'b0;
        end
    end

    // Route is sampled when the sum is taken.
    always_ff @(posedge clk) begin
        if (sum_ack) begin
            pkt_q.data.valid   <= 1'b1;
            pkt_q.data.leaf    <= route_leaf;
            pkt_q.data.port    <= route_port;
            pkt_q.data.addr    <= sum_seq;
            pkt_q.data.payload <= sum_data;
        end
    end

    assign dout = shown ? pkt_q : '0;

    // Tree bus is quiet while the upstream asks for a resend.
    a_resend_quiet: assert property (
        @(posedge clk) disable iff (!rst_n)
        resend |-> (dout == '0)
    ) else $error("dout not zero during resend");

endmodule

// File: design/leaf_i6o1.sv
`timescale 1ns/1ns

module leaf_i6o1 (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic [leaf_pkg::PACKET_BITS-1:0] din_leaf_bft2interface,
    output logic [leaf_pkg::PACKET_BITS-1:0] dout_leaf_interface2bft,
    input  logic                             resend
);

    // Decoder to port buffers.
    logic [leaf_pkg::NUM_IN_PORTS-1:0]    port_wr_en;
    logic [leaf_pkg::PAYLOAD_BITS-1:0]    port_wr_data;

    // Port buffers to kernel.
    logic [leaf_pkg::NUM_IN_PORTS-1:0]                             port_vld;
    logic [leaf_pkg::NUM_IN_PORTS-1:0][leaf_pkg::PAYLOAD_BITS-1:0] port_dout;
    logic [leaf_pkg::NUM_IN_PORTS-1:0]                             port_ack;

    // Kernel to encoder.
    logic                              sum_vld;
    logic [leaf_pkg::PAYLOAD_BITS-1:0] sum_data;
    logic [leaf_pkg::ADDR_BITS-1:0]    sum_seq;
    logic                              sum_ack;

    // Current output route.
    logic [leaf_pkg::LEAF_BITS-1:0] route_leaf;
    logic [leaf_pkg::PORT_BITS-1:0] route_port;

    leaf_packet_decoder decoder_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .din        (din_leaf_bft2interface),
        .wr_en      (port_wr_en),
        .wr_data    (port_wr_data),
        .route_leaf (route_leaf),
        .route_port (route_port)
    );

    // One buffer per user input port, ports 1 to 6.
    for (genvar i = 0; i < leaf_pkg::NUM_IN_PORTS; i++) begin : g_port
        leaf_in_port in_port_i (
            .clk     (clk),
            .rst_n   (rst_n),
            .wr_en   (port_wr_en[i]),
            .wr_data (port_wr_data),
            .vld     (port_vld[i]),
            .dout    (port_dout[i]),
            .ack     (port_ack[i])
        );
    end

    leaf_reduce_kernel kernel_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .vld      (port_vld),
        .din      (port_dout),
        .ack      (port_ack),
        .sum_vld  (sum_vld),
        .sum_data (sum_data),
        .sum_seq  (sum_seq),
        .sum_ack  (sum_ack)
    );

    leaf_packet_encoder encoder_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .sum_vld    (sum_vld),
        .sum_data   (sum_data),
        .sum_seq    (sum_seq),
        .sum_ack    (sum_ack),
        .route_leaf (route_leaf),
        .route_port (route_port),
        .resend     (resend),
        .dout       (dout_leaf_interface2bft)
    );

endmodule

// File: sim/leaf_checker.sv
`timescale 1ns/1ns

module leaf_checker (
    input  logic                   clk,
    input  logic                   rst_n,
    input  leaf_pkg::leaf_packet_u din,
    input  leaf_pkg::leaf_packet_u dout,
    input  logic                   resend,
    input  logic                   end_check,
    input  int                     sent_min,
    output int                     out_count,
    output int                     exp_count,
    output int                     err_count
);

    logic [leaf_pkg::PAYLOAD_BITS-1:0] port_q [leaf_pkg::NUM_IN_PORTS][$];
    leaf_pkg::leaf_packet_u            exp_q [$];     // Packets still owed by the DUT.
    logic [leaf_pkg::LEAF_BITS-1:0]    route_leaf;
    logic [leaf_pkg::PORT_BITS-1:0]    route_port;
    logic [leaf_pkg::ADDR_BITS-1:0]    seq;
    logic                              end_done;

    task automatic compare_field(input string name, input logic [31:0] expv,
                                 input logic [31:0] actv);
        if (actv !== expv) begin
            $display("Fail %s expected %h actual %h", name, expv, actv);
            err_count++;
        end
    endtask

    function automatic bit sets_ready();
        bit ready;
        ready = 1'b1;
        for (int i = 0; i < leaf_pkg::NUM_IN_PORTS; i++) begin
            if (port_q[i].size() == 0) begin
                ready = 1'b0;
            end
        end
        return ready;
    endfunction

    task automatic check_output();
        leaf_pkg::leaf_packet_u expv;
        if (resend && dout !== '0) begin
            $display("Fail resend_quiet expected %h actual %h", 49'h0, dout);
            err_count++;
        end
        if (dout.data.valid === 1'b1) begin
            out_count++;
            if (exp_q.size() == 0) begin
                $display("Output packet %h arrived with no completed set pending", dout);
                err_count++;
            end else begin
                expv = exp_q.pop_front();
                compare_field("sum", expv.data.payload, dout.data.payload);
                compare_field("seq", 32'(expv.data.addr), 32'(dout.data.addr));
                compare_field("route_leaf", 32'(expv.data.leaf), 32'(dout.data.leaf));
                compare_field("route_port", 32'(expv.data.port), 32'(dout.data.port));
            end
        end else if (dout !== '0) begin
            $display("Fail idle_bus expected %h actual %h", 49'h0, dout);
            err_count++;
        end
    endtask

    // Mirrors the leaf. Data words queue per port and a full set becomes one packet.
    task automatic take_input();
        logic [leaf_pkg::PAYLOAD_BITS-1:0] sum;
        leaf_pkg::leaf_packet_u            expv;
        int                                idx;
        if (din.data.valid === 1'b1 && din.data.leaf == leaf_pkg::LEAF_ID) begin
            idx = int'(din.data.port);
            if (din.data.port == leaf_pkg::CFG_PORT) begin
                route_leaf = din.cfg.dest_leaf;
                route_port = din.cfg.dest_port;
            end else if (idx <= leaf_pkg::NUM_IN_PORTS) begin
                port_q[idx - 1].push_back(din.data.payload);
            end
        end
        if (sets_ready()) begin
            sum = '0;
            for (int i = 0; i < leaf_pkg::NUM_IN_PORTS; i++) begin
                sum = sum + port_q[i].pop_front();  // Wraps at 2^32.
            end
            expv = '0;
            expv.data.valid   = 1'b1;
            expv.data.leaf    = route_leaf;
            expv.data.port    = route_port;
            expv.data.addr    = seq;
            expv.data.payload = sum;
            exp_q.push_back(expv);
            seq = seq + 1'b1;
            exp_count++;
        end
    endtask

    // Both buses are settled at the falling edge.
    always @(negedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < leaf_pkg::NUM_IN_PORTS; i++) begin
                port_q[i].delete();
            end
            exp_q.delete();
            route_leaf = '0;
            route_port = '0;
            seq        = '0;
            out_count  = 0;
            exp_count  = 0;
            err_count  = 0;
            end_done   = 1'b0;
        end else begin
            check_output();
            take_input();
            if (end_check && !end_done) begin
                end_done = 1'b1;
                compare_field("drain_count", 32'(sent_min), 32'(out_count));
                compare_field("pending_sets", 32'h0, 32'(exp_q.size()));
            end
        end
    end

endmodule

// File: sim/tb_leaf_i6o1.sv
`timescale 1ns/1ns

module tb_leaf_i6o1;

    localparam int NUM_STEPS     = 1600;
    localparam int DRAIN_TIMEOUT = 400;   // Cycles.

    logic                             clk;
    logic                             rst_n;
    logic                             resend;
    logic [leaf_pkg::PACKET_BITS-1:0] din;
    logic [leaf_pkg::PACKET_BITS-1:0] dout;
    logic                             end_check;
    int                               sent_min;
    int                               out_count;
    int                               exp_count;
    int                               chk_errors;
    int                               tb_errors;
    int                               sent [leaf_pkg::NUM_IN_PORTS];
    integer                           seed;

    always #2 clk = ~clk;

    leaf_i6o1 dut_i (
        .clk                     (clk),
        .rst_n                   (rst_n),
        .din_leaf_bft2interface  (din),
        .dout_leaf_interface2bft (dout),
        .resend                  (resend)
    );

    leaf_checker checker_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .din       (din),
        .dout      (dout),
        .resend    (resend),
        .end_check (end_check),
        .sent_min  (sent_min),
        .out_count (out_count),
        .exp_count (exp_count),
        .err_count (chk_errors)
    );

    function automatic leaf_pkg::leaf_packet_u cfg_packet(
        input logic [leaf_pkg::LEAF_BITS-1:0] dest_leaf,
        input logic [leaf_pkg::PORT_BITS-1:0] dest_port);
        leaf_pkg::leaf_packet_u pkt;
        pkt = '0;
        pkt.cfg.valid     = 1'b1;
        pkt.cfg.leaf      = leaf_pkg::LEAF_ID;
        pkt.cfg.port      = leaf_pkg::CFG_PORT;
        pkt.cfg.dest_leaf = dest_leaf;
        pkt.cfg.dest_port = dest_port;
        return pkt;
    endfunction

    function automatic leaf_pkg::leaf_packet_u data_packet(
        input logic [leaf_pkg::LEAF_BITS-1:0]    leaf,
        input logic [leaf_pkg::PORT_BITS-1:0]    port,
        input logic [leaf_pkg::PAYLOAD_BITS-1:0] payload);
        leaf_pkg::leaf_packet_u pkt;
        pkt = '0;
        pkt.data.valid   = 1'b1;
        pkt.data.leaf    = leaf;
        pkt.data.port    = port;
        pkt.data.payload = payload;
        return pkt;
    endfunction

    // One bus cycle, launched just after the rising edge.
    task automatic drive(input leaf_pkg::leaf_packet_u pkt, input logic rs);
        @(posedge clk);
        #1;
        din    = pkt;
        resend = rs;
    endtask

    task automatic wait_outputs(input int target, input string what);
        int n;
        n = 0;
        while (out_count < target && n < DRAIN_TIMEOUT) begin
            drive('0, 1'b0);
            n++;
        end
        if (out_count < target) begin
            $display("Timeout in %s, saw %0d of %0d output packets", what, out_count, target);
            tb_errors++;
        end
    endtask

    task automatic send_random_step();
        int                                kind;
        int                                p;
        logic                              rs;
        logic [leaf_pkg::PAYLOAD_BITS-1:0] payload;
        logic [leaf_pkg::LEAF_BITS-1:0]    leaf;
        leaf_pkg::leaf_packet_u            pkt;
        rs      = ({$random(seed)} % 8) == 0;
        kind    = {$random(seed)} % 10;
        p       = {$random(seed)} % leaf_pkg::NUM_IN_PORTS;
        payload = $random(seed);
        pkt     = leaf_pkg::PACKET_BITS'({$random(seed), $random(seed)});
        pkt.data.valid = 1'b0;  // Idle unless a case below fills it.
        if (kind == 2) begin
            leaf = leaf_pkg::LEAF_ID ^ leaf_pkg::LEAF_BITS'(1 + {$random(seed)} % 31);
            pkt  = data_packet(leaf, leaf_pkg::PORT_BITS'({$random(seed)} % 16), payload);
        end else if (kind == 3) begin
            pkt = data_packet(leaf_pkg::LEAF_ID, 4'd9, payload);
        end else if (kind >= 4 && sent[p] - out_count < leaf_pkg::FIFO_DEPTH - 2) begin
            pkt = data_packet(leaf_pkg::LEAF_ID, leaf_pkg::PORT_BITS'(p + 1), payload);
            sent[p]++;
        end
        drive(pkt, rs);
    endtask

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        resend    = 1'b0;
        din       = '0;
        end_check = 1'b0;
        sent_min  = 0;
        tb_errors = 0;
        seed      = 30;
        for (int p = 0; p < leaf_pkg::NUM_IN_PORTS; p++) begin
            sent[p] = 0;
        end
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;

        drive(cfg_packet(5'd3, 4'd2), 1'b0);
        for (int i = 0; i < NUM_STEPS; i++) begin
            // Route changes only once every finished set has left.
            if (i == NUM_STEPS / 2) begin
                drive('0, 1'b0);
                wait_outputs(exp_count, "mid-run drain");
                drive(cfg_packet(5'd17, 4'd11), 1'b0);
            end
            send_random_step();
        end
        drive('0, 1'b0);

        sent_min = sent[0];
        for (int p = 1; p < leaf_pkg::NUM_IN_PORTS; p++) begin
            if (sent[p] < sent_min) begin
                sent_min = sent[p];
            end
        end
        wait_outputs(sent_min, "final drain");
        repeat (6) drive('0, 1'b0);  // Room for any stray extra packet.
        end_check = 1'b1;
        repeat (2) drive('0, 1'b0);

        $display("Errors: %0d checker, %0d testbench", chk_errors, tb_errors);
        if (chk_errors == 0 && tb_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: leaf_i6o1.f
design/leaf_pkg.sv
design/leaf_packet_decoder.sv
design/leaf_in_port.sv
design/leaf_reduce_kernel.sv
design/leaf_packet_encoder.sv
design/leaf_i6o1.sv
sim/leaf_checker.sv
sim/tb_leaf_i6o1.sv

// File: Bender.yml
package:
  name: leaf_i6o1

sources:
  - design/leaf_pkg.sv
  - design/leaf_packet_decoder.sv
  - design/leaf_in_port.sv
  - design/leaf_reduce_kernel.sv
  - design/leaf_packet_encoder.sv
  - design/leaf_i6o1.sv
  - target: simulation
    files:
      - sim/leaf_checker.sv
      - sim/tb_leaf_i6o1.sv
